// ==== files.f ====
source/mem_cfg_pkg.sv
source/mem_types_pkg.sv
source/slow_ram.sv
source/bank_port.sv
source/req_dispatch.sv
source/rsp_collect.sv
source/bank_mem_top.sv
test/tb_bank_mem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the banked memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_bank_mem -f files.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_bank_mem)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== test/tb_bank_mem.sv ====
`timescale 1ns/100ps

module tb_bank_mem;

   localparam int WAIT_LIMIT = 200;
   localparam int RAND_OPS   = 40;

   logic                    clk = 1'b0;
   logic                    rst;
   logic                    req;
   mem_types_pkg::mem_req_t req_data;
   logic                    ack;
   logic                    rsp_req;
   mem_types_pkg::mem_rsp_t rsp_data;
   logic                    rsp_ack;

   // Reference memory indexed by the flat word view
   logic [mem_cfg_pkg::DATA_W-1:0] model_q [0:(2 ** mem_cfg_pkg::WORD_ADDR_W)-1];
   mem_types_pkg::mem_rsp_t        exp_rsp [0:(2 ** mem_cfg_pkg::TAG_W)-1];
   logic [(2 ** mem_cfg_pkg::TAG_W)-1:0] pending;
   logic [mem_cfg_pkg::TAG_W-1:0]  next_tag;
   int                             seed;

   always #20 clk = ~clk;

   bank_mem_top u_dut (
      .clk_i      (clk),
      .rst_i      (rst),
      .req_i      (req),
      .req_data_i (req_data),
      .ack_o      (ack),
      .rsp_req_o  (rsp_req),
      .rsp_data_o (rsp_data),
      .rsp_ack_i  (rsp_ack)
   );

   ////////////////////////////////////////////////////////////
   // Failure reporting and compares
   ////////////////////////////////////////////////////////////

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_rsp(input string name, input mem_types_pkg::mem_rsp_t got,
                            input mem_types_pkg::mem_rsp_t exp);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s got tag %h data %h, expected tag %h data %h",
                             name, got.tag, got.data, exp.tag, exp.data));
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s got %h, expected %h", name, got, exp));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Handshake waits, sampled on the falling edge
   ////////////////////////////////////////////////////////////

   task automatic wait_ack(input logic level);
      int n;
      n = 0;
      @(negedge clk);
      while (ack !== level && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (ack !== level) begin
         abort_run($sformatf("Timeout: ack_o never went to %0d on the request port", level));
      end
   endtask

   task automatic wait_rsp_req(input logic level);
      int n;
      n = 0;
      @(negedge clk);
      while (rsp_req !== level && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (rsp_req !== level) begin
         abort_run($sformatf("Timeout: rsp_req_o never went to %0d on the response port",
                             level));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Host request and response handshakes
   ////////////////////////////////////////////////////////////

   // Records the expected old word, then raises the request
   task automatic issue_req(input logic [mem_cfg_pkg::WORD_ADDR_W-1:0] word, input logic we,
                            input logic [mem_cfg_pkg::DATA_W-1:0] wdata);
      mem_types_pkg::mem_req_t r;
      r.addr.flat.word   = word;
      r.addr.flat.offset = '0;
      r.we               = we;
      r.wdata            = wdata;
      r.tag              = next_tag;
      if (pending[next_tag]) begin
         abort_run("Tag reused while its response is still outstanding");
      end
      exp_rsp[next_tag].tag  = next_tag;
      exp_rsp[next_tag].data = model_q[word];
      pending[next_tag]      = 1'b1;
      if (we) begin
         model_q[word] = wdata;
      end
      next_tag = next_tag + 1'b1;
      @(posedge clk);
      req      <= 1'b1;
      req_data <= r;
   endtask

   task automatic finish_req();
      wait_ack(1'b1);
      @(posedge clk);
      req <= 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic send_req(input logic [mem_cfg_pkg::WORD_ADDR_W-1:0] word, input logic we,
                           input logic [mem_cfg_pkg::DATA_W-1:0] wdata);
      issue_req(word, we, wdata);
      finish_req();
   endtask

   // Hold counts cycles with rsp_ack_i kept low after rsp_req_o rises
   task automatic get_rsp(input int hold);
      mem_types_pkg::mem_rsp_t got;
      wait_rsp_req(1'b1);
      got = rsp_data;
      if (!pending[got.tag]) begin
         abort_run($sformatf("Response carries tag %0h with no request outstanding", got.tag));
      end
      check_rsp("rsp_data_o", got, exp_rsp[got.tag]);
      pending[got.tag] = 1'b0;
      repeat (hold) begin
         @(negedge clk);
         check_rsp("rsp_data_o held", rsp_data, got);
      end
      @(posedge clk);
      rsp_ack <= 1'b1;
      wait_rsp_req(1'b0);
      @(posedge clk);
      rsp_ack <= 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////

   task automatic test_reset_read();
      @(negedge clk);
      check_level("ack_o", ack, 1'b0);
      check_level("rsp_req_o", rsp_req, 1'b0);
      send_req(10'd100, 1'b0, '0);
      get_rsp(0);
   endtask

   task automatic test_write_read();
      send_req(10'd5, 1'b1, 32'hcafe_0005);
      get_rsp(2);
      send_req(10'd5, 1'b0, '0);
      get_rsp(0);
   endtask

   // Four neighbouring words hit four banks, all accepted up front
   task automatic test_four_banks();
      for (int w = 16; w < 20; w++) begin
         send_req(10'(w), 1'b1, 32'ha500_0000 | 32'(w));
      end
      repeat (4) get_rsp(1);
   endtask

   task automatic test_busy_bank();
      for (int w = 20; w < 24; w++) begin
         send_req(10'(w), 1'b1, 32'hb000_0000 | 32'(w));
      end
      // Word 20 again, bank 0 still holds an untaken response
      issue_req(10'd20, 1'b0, '0);
      repeat (20) begin
         @(negedge clk);
         check_level("ack_o", ack, 1'b0);
      end
      repeat (4) get_rsp(0);
      finish_req();
      get_rsp(0);
   endtask

   task automatic test_random_mix();
      logic [mem_cfg_pkg::WORD_ADDR_W-1:0] rnd_word [0:RAND_OPS-1];
      logic                                rnd_we   [0:RAND_OPS-1];
      logic [mem_cfg_pkg::DATA_W-1:0]      rnd_data [0:RAND_OPS-1];
      int                                  rnd_hold [0:RAND_OPS-1];
      logic [31:0]                         rnd;
      for (int i = 0; i < RAND_OPS; i++) begin
         rnd         = $random(seed);
         rnd_word[i] = mem_cfg_pkg::WORD_ADDR_W'(rnd[2:0]);
         rnd_we[i]   = rnd[3];
         rnd_hold[i] = int'(rnd[6:4]);
         rnd_data[i] = $random(seed);
      end
      // Issue and collect run side by side so banks overlap
      fork
         begin
            for (int i = 0; i < RAND_OPS; i++) begin
               send_req(rnd_word[i], rnd_we[i], rnd_data[i]);
            end
         end
         begin
            for (int j = 0; j < RAND_OPS; j++) begin
               get_rsp(rnd_hold[j]);
            end
         end
      join
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      rst      = 1'b1;
      req      = 1'b0;
      req_data = '0;
      rsp_ack  = 1'b0;
      pending  = '0;
      next_tag = '0;
      seed     = 28549;
      for (int i = 0; i < 2 ** mem_cfg_pkg::WORD_ADDR_W; i++) begin
         model_q[i] = '0;
      end
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      test_reset_read();
      test_write_read();
      test_four_banks();
      test_busy_bank();
      test_random_mix();

      if (pending != '0) begin
         abort_run("Responses still outstanding at the end of the run");
      end else begin
         $display("PASS: all tests");
         $finish;
      end
   end

endmodule

// ==== source/bank_mem_top.sv ====
`timescale 1ns/100ps

module bank_mem_top (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    req_i,
   input  mem_types_pkg::mem_req_t req_data_i,
   output logic                    ack_o,
   output logic                    rsp_req_o,
   output mem_types_pkg::mem_rsp_t rsp_data_o,
   input  logic                    rsp_ack_i
);

   logic [mem_cfg_pkg::NUM_BANKS-1:0]                      bank_load;
   mem_types_pkg::bank_cmd_t                               bank_cmd;
   logic [mem_cfg_pkg::NUM_BANKS-1:0]                      bank_busy;
   logic [mem_cfg_pkg::NUM_BANKS-1:0]                      bank_done;
   logic [mem_cfg_pkg::NUM_BANKS-1:0]                      bank_take;
   mem_types_pkg::mem_rsp_t [mem_cfg_pkg::NUM_BANKS-1:0]   bank_rsp;

   // Request side
   req_dispatch u_dispatch (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (req_i),
      .req_data_i  (req_data_i),
      .bank_busy_i (bank_busy),
      .ack_o       (ack_o),
      .bank_load_o (bank_load),
      .bank_cmd_o  (bank_cmd)
   );

   // One slot and RAM per bank, command bus shared
   for (genvar b = 0; b < mem_cfg_pkg::NUM_BANKS; b++) begin : g_bank
      bank_port u_bank (
         .clk_i  (clk_i),
         .rst_i  (rst_i),
         .load_i (bank_load[b]),
         .cmd_i  (bank_cmd),
         .take_i (bank_take[b]),
         .busy_o (bank_busy[b]),
         .done_o (bank_done[b]),
         .rsp_o  (bank_rsp[b])
      );
   end

   // Response side
   rsp_collect u_collect (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .bank_done_i (bank_done),
      .bank_rsp_i  (bank_rsp),
      .rsp_ack_i   (rsp_ack_i),
      .bank_take_o (bank_take),
      .rsp_req_o   (rsp_req_o),
      .rsp_data_o  (rsp_data_o)
   );

endmodule

// ==== source/rsp_collect.sv ====
`timescale 1ns/100ps

module rsp_collect (
   input  logic                                                     clk_i,
   input  logic                                                     rst_i,
   input  logic [mem_cfg_pkg::NUM_BANKS-1:0]                        bank_done_i,
   input  mem_types_pkg::mem_rsp_t [mem_cfg_pkg::NUM_BANKS-1:0]     bank_rsp_i,
   input  logic                                                     rsp_ack_i,
   output logic [mem_cfg_pkg::NUM_BANKS-1:0]                        bank_take_o,
   output logic                                                     rsp_req_o,
   output mem_types_pkg::mem_rsp_t                                  rsp_data_o
);

   logic [mem_cfg_pkg::BANK_W-1:0] last_q;
   logic [mem_cfg_pkg::BANK_W-1:0] pick_idx;
   logic                           pick_vld;
   logic                           can_pick;

   ////////////////////////////////////////////////////////////
   // Round-robin pick
   ////////////////////////////////////////////////////////////

   // Search starts just past the last bank served
   always_comb begin
      logic [mem_cfg_pkg::BANK_W-1:0] cand;
      pick_vld = 1'b0;
      pick_idx = last_q;
      for (int i = 1; i <= mem_cfg_pkg::NUM_BANKS; i++) begin
         cand = last_q + i[mem_cfg_pkg::BANK_W-1:0];
         if (!pick_vld && bank_done_i[cand]) begin
            pick_vld = 1'b1;
            pick_idx = cand;
         end
      end
   end

   // Previous handshake fully closed
   assign can_pick = !rsp_req_o && !rsp_ack_i && pick_vld;

   ////////////////////////////////////////////////////////////
   // Host response handshake
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rsp_req_o <= 1'b0;
         last_q    <= '1;
      end else if (can_pick) begin
         rsp_req_o <= 1'b1;
         last_q    <= pick_idx;
      end else if (rsp_req_o && rsp_ack_i) begin
         rsp_req_o <= 1'b0;
      end
   end

   // Response held stable while rsp_req_o is high
   always_ff @(posedge clk_i) begin
      if (can_pick) begin
         rsp_data_o <= bank_rsp_i[pick_idx];
      end
   end

   // Frees the bank on the ack edge
   always_comb begin
      bank_take_o = '0;
      if (rsp_req_o && rsp_ack_i) begin
         bank_take_o[last_q] = 1'b1;
      end
   end

endmodule

// ==== source/req_dispatch.sv ====
`timescale 1ns/100ps

module req_dispatch (
   input  logic                                 clk_i,
   input  logic                                 rst_i,
   input  logic                                 req_i,
   input  mem_types_pkg::mem_req_t              req_data_i,
   input  logic [mem_cfg_pkg::NUM_BANKS-1:0]    bank_busy_i,
   output logic                                 ack_o,
   output logic [mem_cfg_pkg::NUM_BANKS-1:0]    bank_load_o,
   output mem_types_pkg::bank_cmd_t             bank_cmd_o
);

   logic [mem_cfg_pkg::BANK_W-1:0] tgt_bank;
   logic                           accept;

   ////////////////////////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////////////////////////

   assign tgt_bank = req_data_i.addr.banked.bank;

   // New request, not yet acked, and its bank has a free slot
   assign accept = req_i && !ack_o && !bank_busy_i[tgt_bank];

   always_comb begin
      bank_cmd_o.row   = req_data_i.addr.banked.row;
      bank_cmd_o.we    = req_data_i.we;
      bank_cmd_o.wdata = req_data_i.wdata;
      bank_cmd_o.tag   = req_data_i.tag;
   end

   // One-hot load, lasts a single cycle since ack follows
   always_comb begin
      bank_load_o = '0;
      if (accept) begin
         bank_load_o[tgt_bank] = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Host side acknowledge
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else if (accept) begin
         ack_o <= 1'b1;
      end else if (ack_o && !req_i) begin
         // Host has let go, close the handshake
         ack_o <= 1'b0;
      end
   end

endmodule

// ==== source/bank_port.sv ====
`timescale 1ns/100ps

module bank_port (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    load_i,
   input  mem_types_pkg::bank_cmd_t cmd_i,
   input  logic                    take_i,
   output logic                    busy_o,
   output logic                    done_o,
   output mem_types_pkg::mem_rsp_t rsp_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_REL,
      ST_DONE
   } bank_state_t;

   bank_state_t                     state_q;
   mem_types_pkg::bank_cmd_t        cmd_q;
   logic [mem_cfg_pkg::DATA_W-1:0]  rdata_q;
   logic                            ram_req;
   logic                            ram_ack;
   logic [mem_cfg_pkg::DATA_W-1:0]  ram_rdata;

   ////////////////////////////////////////////////////////////
   // Slot control
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: if (load_i) state_q <= ST_REQ;
            // Drop the request once the RAM answers
            ST_REQ:  if (ram_ack) state_q <= ST_REL;
            ST_REL:  if (!ram_ack) state_q <= ST_DONE;
            ST_DONE: if (take_i) state_q <= ST_IDLE;
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Command and returned word
   always_ff @(posedge clk_i) begin
      if (state_q == ST_IDLE && load_i) begin
         cmd_q <= cmd_i;
      end
      if (state_q == ST_REQ && ram_ack) begin
         rdata_q <= ram_rdata;
      end
   end

   assign ram_req = (state_q == ST_REQ);
   assign busy_o  = (state_q != ST_IDLE);
   assign done_o  = (state_q == ST_DONE);

   always_comb begin
      rsp_o.tag  = cmd_q.tag;
      rsp_o.data = rdata_q;
   end

   slow_ram u_ram (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ram_req_i   (ram_req),
      .ram_row_i   (cmd_q.row),
      .ram_we_i    (cmd_q.we),
      .ram_wdata_i (cmd_q.wdata),
      .ram_ack_o   (ram_ack),
      .ram_rdata_o (ram_rdata)
   );

endmodule

// ==== source/slow_ram.sv ====
`timescale 1ns/100ps

module slow_ram (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            ram_req_i,
   input  logic [mem_cfg_pkg::ROW_W-1:0]   ram_row_i,
   input  logic                            ram_we_i,
   input  logic [mem_cfg_pkg::DATA_W-1:0]  ram_wdata_i,
   output logic                            ram_ack_o,
   output logic [mem_cfg_pkg::DATA_W-1:0]  ram_rdata_o
);

   logic [mem_cfg_pkg::DATA_W-1:0]    mem_q [0:(2 ** mem_cfg_pkg::ROW_W)-1];
   logic [mem_cfg_pkg::LAT_CNT_W-1:0] lat_cnt_q;
   logic                              access_hit;

   // Contents start cleared
   initial begin
      for (int i = 0; i < 2 ** mem_cfg_pkg::ROW_W; i++) begin
         mem_q[i] = '0;
      end
   end

   // Last clock of the latency window, only once per request
   assign access_hit = ram_req_i && !ram_ack_o && (lat_cnt_q == 1);

   ////////////////////////////////////////////////////////////
   // Latency counter and acknowledge
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ram_ack_o <= 1'b0;
         lat_cnt_q <= mem_cfg_pkg::LAT_RELOAD;
      end else if (!ram_req_i) begin
         // Request gone, release ack and rearm
         ram_ack_o <= 1'b0;
         lat_cnt_q <= mem_cfg_pkg::LAT_RELOAD;
      end else if (access_hit) begin
         ram_ack_o <= 1'b1;
      end else if (!ram_ack_o) begin
         lat_cnt_q <= lat_cnt_q - 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   // Old word out, new word in on the same edge
   always_ff @(posedge clk_i) begin
      if (access_hit) begin
         ram_rdata_o <= mem_q[ram_row_i];
         if (ram_we_i) begin
            mem_q[ram_row_i] <= ram_wdata_i;
         end
      end
   end

endmodule

// ==== source/mem_types_pkg.sv ====
package mem_types_pkg;

   // Word index with byte offset, as the host sees memory
   typedef struct packed {
      logic [mem_cfg_pkg::WORD_ADDR_W-1:0] word;
      logic [mem_cfg_pkg::DATA_SHIFT-1:0]  offset;
   } mem_addr_flat_t;

   // Bank taken from the low word bits so neighbouring words interleave
   typedef struct packed {
      logic [mem_cfg_pkg::ROW_W-1:0]      row;
      logic [mem_cfg_pkg::BANK_W-1:0]     bank;
      logic [mem_cfg_pkg::DATA_SHIFT-1:0] offset;
   } mem_addr_bank_t;

   // One byte address, two readings of the same bits
   typedef union packed {
      mem_addr_flat_t flat;
      mem_addr_bank_t banked;
   } mem_addr_u;

   // Host request
   typedef struct packed {
      mem_addr_u                       addr;
      logic                            we;
      logic [mem_cfg_pkg::DATA_W-1:0]  wdata;
      logic [mem_cfg_pkg::TAG_W-1:0]   tag;
   } mem_req_t;

   // Data is the word held before the access
   typedef struct packed {
      logic [mem_cfg_pkg::TAG_W-1:0]   tag;
      logic [mem_cfg_pkg::DATA_W-1:0]  data;
   } mem_rsp_t;

   // Command held in a bank slot
   typedef struct packed {
      logic [mem_cfg_pkg::ROW_W-1:0]   row;
      logic                            we;
      logic [mem_cfg_pkg::DATA_W-1:0]  wdata;
      logic [mem_cfg_pkg::TAG_W-1:0]   tag;
   } bank_cmd_t;

endpackage

// ==== source/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

   ////////////////////////////////////////////////////////////
   // Address and data geometry
   ////////////////////////////////////////////////////////////

   localparam int BYTE_ADDR_W = 12;
   // Four bytes per word
   localparam int DATA_SHIFT = 2;
   localparam int DATA_W = (2 ** DATA_SHIFT) * 8;
   localparam int BANK_W = 2;
   localparam int NUM_BANKS = 2 ** BANK_W;
   localparam int WORD_ADDR_W = BYTE_ADDR_W - DATA_SHIFT;
   // Word index inside one bank
   localparam int ROW_W = WORD_ADDR_W - BANK_W;

   ////////////////////////////////////////////////////////////
   // Timing and transaction tags
   ////////////////////////////////////////////////////////////

   // Clocks of ram_req high up to the acknowledge
   localparam int RAM_LATENCY = 3;
   localparam int LAT_CNT_W = $clog2(RAM_LATENCY + 1);
   localparam logic [LAT_CNT_W-1:0] LAT_RELOAD = LAT_CNT_W'(RAM_LATENCY);
   localparam int TAG_W = 4;

endpackage
